// File: src/switch_pkg.sv
package switch_pkg;

    // word and port geometry.
    localparam int data_width = 16;
    localparam int port_num   = 4;
    localparam int sel_width  = $clog2(port_num);

    // packet length limits, in words.
    localparam int len_max    = 16;
    localparam int len_width  = $clog2(len_max + 1);

    // queue depths.
    localparam int data_depth = 32;
    localparam int desc_depth = 4;

    // one entry per stored packet.
    typedef struct packed {
        logic [sel_width-1:0] dest;
        logic [len_width-1:0] length;
        logic                 error;
    } pkt_desc_t;

endpackage

// File: src/sync_fifo.sv
module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wr_en,
    input  payload_t wr_data,
    input  logic     rd_en,
    output payload_t rd_data,
    output logic     full,
    output logic     empty
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic [cnt_w-1:0] count_nxt;
    logic             do_wr;
    logic             do_rd;

    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // show-ahead head.
    assign rd_data = mem[rd_ptr];

    always_comb begin
        count_nxt = count;
        if (do_wr && !do_rd) begin
            count_nxt = count + 1'b1;
        end else if (do_rd && !do_wr) begin
            count_nxt = count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full   <= 1'b0;
            empty  <= 1'b1;
        end else begin
            if (do_wr) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count_nxt;
            // flags follow the next count.
            full  <= (count_nxt == cnt_w'(depth));
            empty <= (count_nxt == '0);
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) rd_en |-> !empty);

endmodule

// File: src/in_wr_controller.sv
module in_wr_controller (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                in_valid,
    input  logic                                in_sop,
    input  logic                                in_eop,
    input  logic [switch_pkg::data_width-1:0]   in_data,
    input  logic [switch_pkg::sel_width-1:0]    in_dest,
    input  logic                                in_error,
    output logic                                in_ready,
    input  logic                                data_full,
    input  logic                                desc_full,
    output logic                                data_wr_en,
    output logic [switch_pkg::data_width-1:0]   data_wr_data,
    output logic                                desc_wr_en,
    output switch_pkg::pkt_desc_t               desc_wr_data
);

    import switch_pkg::*;

    logic                 accept;
    logic                 in_pkt;
    logic [sel_width-1:0] dest_reg;
    logic [len_width-1:0] len_cnt;
    logic                 err_reg;
    logic [sel_width-1:0] cur_dest;
    logic [len_width-1:0] cur_len;
    logic                 cur_err;

    // room for a word and a possible descriptor.
    assign in_ready = !data_full && !desc_full;
    assign accept   = in_valid && in_ready;

    // running values including the word on the link.
    assign cur_dest = in_sop ? in_dest : dest_reg;
    assign cur_len  = in_sop ? len_width'(1) : len_width'(len_cnt + 1'b1);
    assign cur_err  = in_error || (!in_sop && err_reg);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_pkt   <= 1'b0;
            dest_reg <= '0;
            len_cnt  <= '0;
            err_reg  <= 1'b0;
        end else if (accept) begin
            in_pkt   <= !in_eop;
            dest_reg <= cur_dest;
            len_cnt  <= cur_len;
            err_reg  <= cur_err;
        end
    end

    assign data_wr_en   = accept;
    assign data_wr_data = in_data;

    // descriptor goes in with the eop word.
    assign desc_wr_en          = accept && in_eop;
    assign desc_wr_data.dest   = cur_dest;
    assign desc_wr_data.length = cur_len;
    assign desc_wr_data.error  = cur_err;

    a_sop_outside_pkt: assert property (
        @(posedge clk) disable iff (!rst_n)
        accept && in_sop |-> !in_pkt
    );

    a_len_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        desc_wr_en |-> (desc_wr_data.length <= len_width'(len_max))
    );

endmodule

// File: src/in_rd_controller_fsm.sv
module in_rd_controller_fsm (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start,
    input  logic [switch_pkg::sel_width-1:0]    rx_in,
    input  logic [switch_pkg::port_num-1:0]     full_in,
    input  logic                                error_in,
    input  logic [switch_pkg::len_width-1:0]    data_length,
    input  logic                                grant,
    input  logic                                data_empty,
    output logic [switch_pkg::sel_width-1:0]    rx_out,
    output logic                                req,
    output logic                                fifo_rd_en,
    output logic                                out_valid,
    output logic                                ready,
    output logic                                out_sel
);

    import switch_pkg::*;

    typedef enum logic [2:0] {
        st_idle = 3'b000,
        st_wait = 3'b001,
        st_load = 3'b011,
        st_rd   = 3'b010,
        st_done = 3'b111
    } state_t;

    state_t               state;
    state_t               state_n;
    logic [len_width-1:0] len_reg;
    logic                 error_reg;
    logic [sel_width-1:0] rx_reg;
    logic [len_width-1:0] cnt;
    logic [len_width-1:0] last_idx;
    logic                 cnt_eq_length;
    logic                 desc_load;
    logic                 cnt_add;
    logic                 cnt_rst;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            len_reg   <= '0;
            error_reg <= 1'b0;
            rx_reg    <= '0;
        end else if (desc_load) begin
            len_reg   <= data_length;
            error_reg <= error_in;
            rx_reg    <= rx_in;
        end
    end

    assign rx_out = rx_reg;

    // words after the first one.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (cnt_rst) begin
            cnt <= '0;
        end else if (cnt_add) begin
            cnt <= cnt + 1'b1;
        end
    end

    assign last_idx      = len_reg - 1'b1;
    assign cnt_eq_length = (cnt == last_idx);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_n;
        end
    end

    always_comb begin
        state_n    = state;
        desc_load  = 1'b0;
        cnt_add    = 1'b0;
        cnt_rst    = 1'b0;
        ready      = 1'b0;
        req        = 1'b0;
        fifo_rd_en = 1'b0;
        out_sel    = 1'b0;
        case (state)
            st_idle: begin
                // only the addressed output matters.
                if (start && !full_in[rx_in]) begin
                    ready     = 1'b1;
                    desc_load = 1'b1;
                    state_n   = st_wait;
                end
            end
            st_wait: begin
                req = 1'b1;
                if (grant) begin
                    state_n = st_load;
                end
            end
            st_load: begin
                fifo_rd_en = 1'b1;
                out_sel    = !error_reg;
                state_n    = st_rd;
            end
            st_rd: begin
                cnt_add = 1'b1;
                if (cnt_eq_length) begin
                    state_n = st_done;
                end else begin
                    fifo_rd_en = 1'b1;
                end
            end
            st_done: begin
                cnt_rst = 1'b1;
                state_n = st_idle;
            end
            default: begin
                state_n = st_idle;
            end
        endcase
    end

    // errored packets drain without a valid.
    assign out_valid = fifo_rd_en && !error_reg;

    a_rd_not_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        fifo_rd_en |-> !data_empty
    );

endmodule

// File: src/in_port_top.sv
module in_port_top (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                in_valid,
    input  logic                                in_sop,
    input  logic                                in_eop,
    input  logic [switch_pkg::data_width-1:0]   in_data,
    input  logic [switch_pkg::sel_width-1:0]    in_dest,
    input  logic                                in_error,
    output logic                                in_ready,
    input  logic [switch_pkg::port_num-1:0]     out_full,
    input  logic                                grant,
    output logic                                req,
    output logic [switch_pkg::sel_width-1:0]    out_dest,
    output logic [switch_pkg::data_width-1:0]   out_data,
    output logic                                out_valid,
    output logic                                out_sop
);

    import switch_pkg::*;

    logic                  data_wr_en;
    logic [data_width-1:0] data_wr_data;
    logic                  data_full;
    logic                  data_empty;
    logic                  fifo_rd_en;
    logic                  desc_wr_en;
    pkt_desc_t             desc_wr_data;
    pkt_desc_t             desc_head;
    logic                  desc_full;
    logic                  desc_empty;
    logic                  desc_pop;

    in_wr_controller u_wr (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_sop       (in_sop),
        .in_eop       (in_eop),
        .in_data      (in_data),
        .in_dest      (in_dest),
        .in_error     (in_error),
        .in_ready     (in_ready),
        .data_full    (data_full),
        .desc_full    (desc_full),
        .data_wr_en   (data_wr_en),
        .data_wr_data (data_wr_data),
        .desc_wr_en   (desc_wr_en),
        .desc_wr_data (desc_wr_data)
    );

    sync_fifo #(
        .payload_t (logic [data_width-1:0]),
        .depth     (data_depth)
    ) u_data_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (data_wr_en),
        .wr_data (data_wr_data),
        .rd_en   (fifo_rd_en),
        .rd_data (out_data),
        .full    (data_full),
        .empty   (data_empty)
    );

    sync_fifo #(
        .payload_t (pkt_desc_t),
        .depth     (desc_depth)
    ) u_desc_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (desc_wr_en),
        .wr_data (desc_wr_data),
        .rd_en   (desc_pop),
        .rd_data (desc_head),
        .full    (desc_full),
        .empty   (desc_empty)
    );

    // a waiting descriptor starts the controller.
    in_rd_controller_fsm u_rd (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (!desc_empty),
        .rx_in       (desc_head.dest),
        .full_in     (out_full),
        .error_in    (desc_head.error),
        .data_length (desc_head.length),
        .grant       (grant),
        .data_empty  (data_empty),
        .rx_out      (out_dest),
        .req         (req),
        .fifo_rd_en  (fifo_rd_en),
        .out_valid   (out_valid),
        .ready       (desc_pop),
        .out_sel     (out_sop)
    );

endmodule

// File: bench/tb_in_port.sv
module tb_in_port;

    timeunit 1ns;
    timeprecision 1ps;

    import switch_pkg::*;

    localparam int wait_limit = 2000;

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid;
    logic                  in_sop;
    logic                  in_eop;
    logic [data_width-1:0] in_data;
    logic [sel_width-1:0]  in_dest;
    logic                  in_error;
    logic                  in_ready;
    logic [port_num-1:0]   out_full;
    logic                  grant;
    logic                  req;
    logic [sel_width-1:0]  out_dest;
    logic [data_width-1:0] out_data;
    logic                  out_valid;
    logic                  out_sop;

    // expected good packets, oldest first.
    logic [sel_width-1:0]  exp_dest[$];
    int                    exp_len[$];
    logic [data_width-1:0] exp_words[$];

    int   cyc = 0;
    int   errors = 0;
    int   timeouts = 0;
    int   rx_count = 0;
    int   sop_cyc = 0;
    int   stall_cycles = 0;
    int   grant_cyc;
    int   grant_delay = 0;
    logic grant_hold = 1'b0;

    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    in_port_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_sop    (in_sop),
        .in_eop    (in_eop),
        .in_data   (in_data),
        .in_dest   (in_dest),
        .in_error  (in_error),
        .in_ready  (in_ready),
        .out_full  (out_full),
        .grant     (grant),
        .req       (req),
        .out_dest  (out_dest),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_sop   (out_sop)
    );

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("ERROR t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
        errors++;
    endtask

    // fabric model answering req after grant_delay cycles.
    initial begin : fabric
        int waited;
        waited = 0;
        grant = 1'b0;
        grant_cyc = 0;
        forever begin
            @(negedge clk);
            if (grant_hold) begin
                grant = 1'b1;
            end else if (!req) begin
                grant = 1'b0;
                waited = 0;
            end else if (!grant) begin
                if (waited >= grant_delay) begin
                    grant = 1'b1;
                    grant_cyc = cyc;
                end else begin
                    waited++;
                end
            end
        end
    end

    // output monitor against the expected queue.
    initial begin : monitor
        int                    rem;
        int                    idx;
        logic [sel_width-1:0]  cur_dest;
        logic [data_width-1:0] word;
        rem = 0;
        idx = 0;
        cur_dest = '0;
        forever begin
            @(negedge clk);
            if (rst_n) begin
                if (!in_ready) begin
                    stall_cycles <= stall_cycles + 1;
                end
                if (out_sop && !out_valid) begin
                    $display("ERROR t=%0t out_sop high without out_valid", $time);
                    errors++;
                end
                if (out_valid) begin
                    if (rem == 0) begin
                        if (exp_len.size() == 0) begin
                            $display("ERROR t=%0t output word while no packet expected", $time);
                            errors++;
                        end else begin
                            rem = exp_len.pop_front();
                            cur_dest = exp_dest.pop_front();
                            idx = 0;
                            sop_cyc <= cyc;
                        end
                    end
                    if (rem != 0) begin
                        word = exp_words.pop_front();
                        if (out_sop !== (idx == 0)) begin
                            report_mismatch("out_sop", 32'(out_sop), 32'(idx == 0));
                        end
                        if (out_dest !== cur_dest) begin
                            report_mismatch("out_dest", 32'(out_dest), 32'(cur_dest));
                        end
                        if (out_data !== word) begin
                            report_mismatch("out_data", 32'(out_data), 32'(word));
                        end
                        idx++;
                        rem--;
                        if (rem == 0) begin
                            rx_count <= rx_count + 1;
                        end
                    end
                end else if (rem != 0) begin
                    $display("ERROR t=%0t gap in packet, %0d words missing", $time, rem);
                    errors++;
                    repeat (rem) void'(exp_words.pop_front());
                    rem = 0;
                end
            end
        end
    end

    // err_pos below zero marks a good packet.
    task automatic send_packet(input logic [sel_width-1:0] dest, input int len,
                               input int err_pos);
        logic [data_width-1:0] words [len_max];
        int                    i;
        int                    n;
        for (i = 0; i < len; i++) begin
            words[i] = data_width'($urandom);
        end
        if (err_pos < 0) begin
            exp_dest.push_back(dest);
            exp_len.push_back(len);
            for (i = 0; i < len; i++) begin
                exp_words.push_back(words[i]);
            end
        end
        for (i = 0; i < len; i++) begin
            in_valid = 1'b1;
            in_sop   = (i == 0);
            in_eop   = (i == len - 1);
            in_data  = words[i];
            in_dest  = dest;
            in_error = (i == err_pos);
            n = 0;
            while (!in_ready && n < wait_limit) begin
                @(negedge clk);
                n++;
            end
            if (!in_ready) begin
                $display("ERROR t=%0t link word %0d was never accepted", $time, i);
                timeouts++;
            end
            @(negedge clk);
        end
        in_valid = 1'b0;
        in_sop   = 1'b0;
        in_eop   = 1'b0;
        in_error = 1'b0;
    endtask

    task automatic wait_packets(input int target);
        int n;
        n = 0;
        while (rx_count < target && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (rx_count < target) begin
            $display("ERROR t=%0t timed out waiting for packet %0d", $time, target);
            timeouts++;
        end
    endtask

    task automatic reset_and_basic_packet();
        int target;
        if (req !== 1'b0) begin
            report_mismatch("req", 32'(req), 0);
        end
        if (out_valid !== 1'b0) begin
            report_mismatch("out_valid", 32'(out_valid), 0);
        end
        if (out_sop !== 1'b0) begin
            report_mismatch("out_sop", 32'(out_sop), 0);
        end
        if (in_ready !== 1'b1) begin
            report_mismatch("in_ready", 32'(in_ready), 1);
        end
        grant_delay = 0;
        target = rx_count + 1;
        send_packet(2'd1, 5, -1);
        wait_packets(target);
    endtask

    task automatic delayed_grant_timing();
        int target;
        grant_delay = $urandom_range(20, 0);
        target = rx_count + 1;
        send_packet(2'd2, 9, -1);
        wait_packets(target);
        // first word in the cycle after grant is sampled.
        if (sop_cyc != grant_cyc + 1) begin
            report_mismatch("first word cycle", sop_cyc, grant_cyc + 1);
        end
        grant_delay = 0;
    endtask

    task automatic error_packet_drop();
        int target;
        target = rx_count + 1;
        send_packet(2'd3, 4, 2);
        send_packet(2'd0, 6, -1);
        wait_packets(target);
    endtask

    task automatic output_full_hold();
        logic [sel_width-1:0] dest;
        int                   target;
        int                   i;
        dest = 2'd2;
        out_full = port_num'(1) << dest;
        target = rx_count + 1;
        send_packet(dest, 7, -1);
        for (i = 0; i < 30; i++) begin
            @(negedge clk);
            if (req !== 1'b0) begin
                report_mismatch("req", 32'(req), 0);
            end
        end
        // other outputs full must not block this one.
        out_full = ~(port_num'(1) << dest);
        wait_packets(target);
        out_full = '0;
    endtask

    task automatic back_to_back_queueing();
        int                   lens [6];
        logic [sel_width-1:0] dests [6];
        int                   target;
        int                   stalls_before;
        int                   i;
        // three one-word packets behind a long one fill the descriptor FIFO.
        lens[0] = len_max;
        lens[1] = 1;
        lens[2] = 1;
        lens[3] = 1;
        lens[4] = $urandom_range(len_max, 1);
        lens[5] = $urandom_range(len_max, 1);
        for (i = 0; i < 6; i++) begin
            dests[i] = sel_width'($urandom);
        end
        grant_hold = 1'b1;
        target = rx_count + 6;
        stalls_before = stall_cycles;
        for (i = 0; i < 6; i++) begin
            send_packet(dests[i], lens[i], -1);
        end
        wait_packets(target);
        if (stall_cycles == stalls_before) begin
            $display("ERROR t=%0t in_ready never dropped while packets queued", $time);
            errors++;
        end
        grant_hold = 1'b0;
    endtask

    initial begin
        void'($urandom(27181));
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_sop   = 1'b0;
        in_eop   = 1'b0;
        in_data  = '0;
        in_dest  = '0;
        in_error = 1'b0;
        out_full = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        reset_and_basic_packet();
        delayed_grant_timing();
        error_packet_drop();
        output_full_hold();
        back_to_back_queueing();

        repeat (10) @(negedge clk);
        if (exp_len.size() != 0) begin
            $display("ERROR t=%0t %0d expected packets never arrived", $time, exp_len.size());
            errors++;
        end
        $display("packets received %0d, errors %0d, timeouts %0d", rx_count, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
src/switch_pkg.sv
src/sync_fifo.sv
src/in_wr_controller.sv
src/in_rd_controller_fsm.sv
src/in_port_top.sv
bench/tb_in_port.sv

// File: Makefile
TOP = tb_in_port

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f flist.f
	./obj_dir/V$(TOP) | tee run.log
	grep -q "ALL TESTS PASSED" run.log

clean:
	rm -rf obj_dir run.log
